/* src/bus_pkg.sv */
package bus_pkg;

  // core-local timer, read-only words
  localparam logic [31:0] RTC_ADDR_LO = 32'h0200_bff8;
  localparam logic [31:0] RTC_ADDR_HI = 32'h0200_bffc;

  // axi size codes
  localparam logic [2:0] SIZE_BYTE = 3'd0;
  localparam logic [2:0] SIZE_HALF = 3'd1;
  localparam logic [2:0] SIZE_WORD = 3'd2;

  // requester strobe patterns, one per size
  localparam logic [7:0] STRB_BYTE = 8'h01;
  localparam logic [7:0] STRB_HALF = 8'h03;
  localparam logic [7:0] STRB_WORD = 8'h0f;

  // axi field widths
  localparam int AXI_LEN_W = 8;
  localparam int AXI_ID_W  = 4;

  // single beat, single id
  localparam logic [AXI_LEN_W-1:0] AXI_LEN_SINGLE = '0;
  localparam logic [AXI_ID_W-1:0]  AXI_ID_DEFAULT = '0;

  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [1:0] RESP_OKAY  = 2'b00;

endpackage

/* src/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,

  // ifu
  input  logic [ADDR_W-1:0] ifu_araddr_i,
  input  logic              ifu_arvalid_i,
  output logic [DATA_W-1:0] ifu_rdata_o,
  output logic              ifu_rvalid_o,

  // lsu load
  input  logic [ADDR_W-1:0] lsu_araddr_i,
  input  logic              lsu_arvalid_i,
  input  logic [7:0]        lsu_rstrb_i,
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic              lsu_rvalid_o,

  // lsu store
  input  logic [ADDR_W-1:0] lsu_awaddr_i,
  input  logic              lsu_awvalid_i,
  input  logic              lsu_wvalid_i,
  output logic              lsu_wready_o,

  // axi master handshakes
  output logic [ADDR_W-1:0] m_araddr_o,
  output logic              m_arvalid_o,
  input  logic              m_arready_i,
  output logic [ADDR_W-1:0] m_awaddr_o,
  output logic              m_awvalid_o,
  input  logic              m_awready_i,
  output logic              m_wvalid_o,
  input  logic              m_wready_i,
  input  logic              m_rvalid_i,
  input  logic [1:0]        m_rresp_i,
  input  logic              m_bvalid_i,
  input  logic [1:0]        m_bresp_i,

  // lane aligner
  input  logic [DATA_W-1:0] rd_word_i,
  output logic [ADDR_W-1:0] rd_addr_o,
  output logic [7:0]        rd_strb_o,

  // timer
  output logic              clint_arvalid_o,
  input  logic [DATA_W-1:0] clint_rdata_i,
  input  logic              clint_rvalid_i
);

  localparam logic [2:0] IDLE     = 3'd0;
  localparam logic [2:0] IF_DATA  = 3'd1;
  localparam logic [2:0] LS_ADDR  = 3'd2;
  localparam logic [2:0] LS_READ  = 3'd3;
  localparam logic [2:0] LS_WRITE = 3'd4;

  logic [2:0] state;
  logic       ar_pend;   // ar not yet accepted
  logic       aw_pend;
  logic       w_pend;
  logic       op_wr;     // lsu op is a store
  logic       clint_sel; // lsu load served by timer
  logic       st_req;
  logic       rtc_hit;
  logic       ar_hs;
  logic       aw_done;
  logic       w_done;

  assign st_req  = lsu_awvalid_i & lsu_wvalid_i;
  assign rtc_hit = (lsu_araddr_i == ADDR_W'(bus_pkg::RTC_ADDR_LO)) |
                   (lsu_araddr_i == ADDR_W'(bus_pkg::RTC_ADDR_HI));

  assign ar_hs   = ar_pend & m_arready_i;
  assign aw_done = ~aw_pend | m_awready_i;
  assign w_done  = ~w_pend | m_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= IDLE;
      ar_pend   <= 1'b0;
      aw_pend   <= 1'b0;
      w_pend    <= 1'b0;
      op_wr     <= 1'b0;
      clint_sel <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          // lsu first, a waiting fetch is passed over
          if (lsu_arvalid_i)
          begin
            state     <= LS_ADDR;
            op_wr     <= 1'b0;
            clint_sel <= rtc_hit;
            ar_pend   <= ~rtc_hit;
          end
          else if (st_req)
          begin
            state     <= LS_ADDR;
            op_wr     <= 1'b1;
            clint_sel <= 1'b0;
            aw_pend   <= 1'b1;
            w_pend    <= 1'b1;
          end
          else if (ifu_arvalid_i)
          begin
            state     <= IF_DATA;
            clint_sel <= 1'b0;
            ar_pend   <= 1'b1;
          end
        end
        IF_DATA:
        begin
          if (ar_hs)
            ar_pend <= 1'b0;
          if (m_rvalid_i)
            state <= IDLE;
        end
        LS_ADDR:
        begin
          if (op_wr)
          begin
            if (m_awready_i)
              aw_pend <= 1'b0;
            if (m_wready_i)
              w_pend <= 1'b0;
            if (aw_done & w_done)
              state <= LS_WRITE;
          end
          else
          begin
            if (ar_hs)
              ar_pend <= 1'b0;
            if (clint_sel | ar_hs)
              state <= LS_READ;
          end
        end
        LS_READ:
        begin
          if (lsu_rvalid_o)
            state <= IDLE;
        end
        LS_WRITE:
        begin
          if (m_bvalid_i)
            state <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  assign m_araddr_o  = (state == IF_DATA) ? ifu_araddr_i : lsu_araddr_i;
  assign m_arvalid_o = ar_pend;
  assign m_awaddr_o  = lsu_awaddr_i;
  assign m_awvalid_o = aw_pend;
  assign m_wvalid_o  = w_pend;

  // active address and size for the aligner, fetches are always full words
  assign rd_addr_o = (state == IF_DATA) ? ifu_araddr_i :
                     (op_wr ? lsu_awaddr_i : lsu_araddr_i);
  assign rd_strb_o = (state == IF_DATA) ? bus_pkg::STRB_WORD : lsu_rstrb_i;

  assign clint_arvalid_o = (state == LS_ADDR) & ~op_wr & clint_sel;

  assign ifu_rdata_o  = rd_word_i;
  assign ifu_rvalid_o = (state == IF_DATA) & m_rvalid_i;

  assign lsu_rdata_o  = clint_sel ? clint_rdata_i : rd_word_i;
  assign lsu_rvalid_o = (state == LS_READ) & (clint_sel ? clint_rvalid_i : m_rvalid_i);
  assign lsu_wready_o = (state == LS_WRITE) & m_bvalid_i;

  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_rresp_i == bus_pkg::RESP_OKAY);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> m_bresp_i == bus_pkg::RESP_OKAY);

  // one transaction in flight
  a_ar_aw_excl: assert property (@(posedge clk) disable iff (rst)
    !(m_arvalid_o && m_awvalid_o));

  a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

endmodule

/* src/axi_lane_align.sv */
`timescale 1ns/10ps

module axi_lane_align #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic [ADDR_W-1:0]   addr_i,
  input  logic [7:0]          rstrb_i,
  input  logic [7:0]          wstrb_i,
  input  logic [DATA_W-1:0]   wdata_i,
  input  logic [2*DATA_W-1:0] rdata64_i,
  output logic [2:0]          arsize_o,
  output logic [2:0]          awsize_o,
  output logic [2*DATA_W-1:0] wdata64_o,
  output logic [DATA_W/4-1:0] wstrb64_o,
  output logic [DATA_W-1:0]   rd_word_o
);

  localparam int SB = DATA_W / 8;   // bytes per word
  localparam int LB = $clog2(SB);   // byte lane bits

  function automatic logic [2:0] size_of(input logic [7:0] strb);
    case (strb)
      bus_pkg::STRB_BYTE: size_of = bus_pkg::SIZE_BYTE;
      bus_pkg::STRB_HALF: size_of = bus_pkg::SIZE_HALF;
      bus_pkg::STRB_WORD: size_of = bus_pkg::SIZE_WORD;
      default:            size_of = bus_pkg::SIZE_WORD; // anything else as full word
    endcase
  endfunction

  logic [LB-1:0]     lane;
  logic              half;
  logic [DATA_W-1:0] wdata_sh;
  logic [SB-1:0]     strb_sh;

  assign lane = addr_i[LB-1:0];
  assign half = addr_i[LB];      // upper word of the beat

  assign arsize_o = size_of(rstrb_i);
  assign awsize_o = size_of(wstrb_i);

  // data moves to its byte lane, copied into both halves
  assign wdata_sh  = wdata_i << {lane, 3'b000};
  assign wdata64_o = {wdata_sh, wdata_sh};

  // strobe only enables the addressed half
  assign strb_sh   = wstrb_i[SB-1:0] << lane;
  assign wstrb64_o = half ? {strb_sh, {SB{1'b0}}} : {{SB{1'b0}}, strb_sh};

  assign rd_word_o = half ? rdata64_i[2*DATA_W-1:DATA_W] : rdata64_i[DATA_W-1:0];

endmodule

/* src/clint_timer.sv */
`timescale 1ns/10ps

module clint_timer #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rvalid_o
);

  logic [2*DATA_W-1:0] mtime;
  logic                sel_hi;

  assign sel_hi = (araddr_i == ADDR_W'(bus_pkg::RTC_ADDR_HI));

  // one tick per clock
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime <= '0;
    else
      mtime <= mtime + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_o <= 1'b0;
    else
      rvalid_o <= arvalid_i;
  end

  // word captured on a read
  always_ff @(posedge clk)
  begin
    if (arvalid_i)
      rdata_o <= sel_hi ? mtime[2*DATA_W-1:DATA_W] : mtime[DATA_W-1:0];
  end

  // arbiter leaves a gap between timer reads
  a_no_back_to_back: assert property (@(posedge clk) disable iff (rst)
    rvalid_o |-> !arvalid_i);

endmodule

/* src/core_bus_top.sv */
`timescale 1ns/10ps

module core_bus_top #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                         clk,
  input  logic                         rst,

  // ifu
  input  logic [ADDR_W-1:0]            ifu_araddr_i,
  input  logic                         ifu_arvalid_i,
  output logic [DATA_W-1:0]            ifu_rdata_o,
  output logic                         ifu_rvalid_o,

  // lsu load
  input  logic [ADDR_W-1:0]            lsu_araddr_i,
  input  logic                         lsu_arvalid_i,
  input  logic [7:0]                   lsu_rstrb_i,
  output logic [DATA_W-1:0]            lsu_rdata_o,
  output logic                         lsu_rvalid_o,

  // lsu store
  input  logic [ADDR_W-1:0]            lsu_awaddr_i,
  input  logic                         lsu_awvalid_i,
  input  logic [DATA_W-1:0]            lsu_wdata_i,
  input  logic [7:0]                   lsu_wstrb_i,
  input  logic                         lsu_wvalid_i,
  output logic                         lsu_wready_o,

  // axi4 master
  output logic [1:0]                   io_master_arburst_o,
  output logic [2:0]                   io_master_arsize_o,
  output logic [bus_pkg::AXI_LEN_W-1:0] io_master_arlen_o,
  output logic [bus_pkg::AXI_ID_W-1:0] io_master_arid_o,
  output logic [ADDR_W-1:0]            io_master_araddr_o,
  output logic                         io_master_arvalid_o,
  input  logic                         io_master_arready_i,

  input  logic [2*DATA_W-1:0]          io_master_rdata_i,
  input  logic [1:0]                   io_master_rresp_i,
  input  logic                         io_master_rvalid_i,
  output logic                         io_master_rready_o,

  output logic [1:0]                   io_master_awburst_o,
  output logic [2:0]                   io_master_awsize_o,
  output logic [bus_pkg::AXI_LEN_W-1:0] io_master_awlen_o,
  output logic [bus_pkg::AXI_ID_W-1:0] io_master_awid_o,
  output logic [ADDR_W-1:0]            io_master_awaddr_o,
  output logic                         io_master_awvalid_o,
  input  logic                         io_master_awready_i,

  output logic                         io_master_wlast_o,
  output logic [2*DATA_W-1:0]          io_master_wdata_o,
  output logic [DATA_W/4-1:0]          io_master_wstrb_o,
  output logic                         io_master_wvalid_o,
  input  logic                         io_master_wready_i,

  input  logic [1:0]                   io_master_bresp_i,
  input  logic                         io_master_bvalid_i,
  output logic                         io_master_bready_o
);

  logic [DATA_W-1:0] rd_word;
  logic [ADDR_W-1:0] rd_addr;
  logic [7:0]        rd_strb;
  logic              clint_arvalid;
  logic [DATA_W-1:0] clint_rdata;
  logic              clint_rvalid;

  // single beat, fixed fields
  assign io_master_arburst_o = bus_pkg::BURST_INCR;
  assign io_master_arlen_o   = bus_pkg::AXI_LEN_SINGLE;
  assign io_master_arid_o    = bus_pkg::AXI_ID_DEFAULT;
  assign io_master_awburst_o = bus_pkg::BURST_INCR;
  assign io_master_awlen_o   = bus_pkg::AXI_LEN_SINGLE;
  assign io_master_awid_o    = bus_pkg::AXI_ID_DEFAULT;
  assign io_master_wlast_o   = 1'b1;
  assign io_master_rready_o  = 1'b1;
  assign io_master_bready_o  = 1'b1;

  mem_arbiter #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) mem_arbiter_inst (
    .clk             (clk),
    .rst             (rst),
    .ifu_araddr_i    (ifu_araddr_i),
    .ifu_arvalid_i   (ifu_arvalid_i),
    .ifu_rdata_o     (ifu_rdata_o),
    .ifu_rvalid_o    (ifu_rvalid_o),
    .lsu_araddr_i    (lsu_araddr_i),
    .lsu_arvalid_i   (lsu_arvalid_i),
    .lsu_rstrb_i     (lsu_rstrb_i),
    .lsu_rdata_o     (lsu_rdata_o),
    .lsu_rvalid_o    (lsu_rvalid_o),
    .lsu_awaddr_i    (lsu_awaddr_i),
    .lsu_awvalid_i   (lsu_awvalid_i),
    .lsu_wvalid_i    (lsu_wvalid_i),
    .lsu_wready_o    (lsu_wready_o),
    .m_araddr_o      (io_master_araddr_o),
    .m_arvalid_o     (io_master_arvalid_o),
    .m_arready_i     (io_master_arready_i),
    .m_awaddr_o      (io_master_awaddr_o),
    .m_awvalid_o     (io_master_awvalid_o),
    .m_awready_i     (io_master_awready_i),
    .m_wvalid_o      (io_master_wvalid_o),
    .m_wready_i      (io_master_wready_i),
    .m_rvalid_i      (io_master_rvalid_i),
    .m_rresp_i       (io_master_rresp_i),
    .m_bvalid_i      (io_master_bvalid_i),
    .m_bresp_i       (io_master_bresp_i),
    .rd_word_i       (rd_word),
    .rd_addr_o       (rd_addr),
    .rd_strb_o       (rd_strb),
    .clint_arvalid_o (clint_arvalid),
    .clint_rdata_i   (clint_rdata),
    .clint_rvalid_i  (clint_rvalid)
  );

  axi_lane_align #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) axi_lane_align_inst (
    .addr_i    (rd_addr),
    .rstrb_i   (rd_strb),
    .wstrb_i   (lsu_wstrb_i),
    .wdata_i   (lsu_wdata_i),
    .rdata64_i (io_master_rdata_i),
    .arsize_o  (io_master_arsize_o),
    .awsize_o  (io_master_awsize_o),
    .wdata64_o (io_master_wdata_o),
    .wstrb64_o (io_master_wstrb_o),
    .rd_word_o (rd_word)
  );

  clint_timer #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) clint_timer_inst (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (lsu_araddr_i),
    .arvalid_i (clint_arvalid),
    .rdata_o   (clint_rdata),
    .rvalid_o  (clint_rvalid)
  );

endmodule

/* testbench/tb_tests.svh */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic settle();
  repeat (2) @(negedge clk);
  #1;
endtask

task automatic check_valids_low();
  check_val("valids", 64'({arvalid, awvalid, wvalid, ifu_rvalid_o, lsu_rvalid_o,
            lsu_wready_o}), 64'h0);
endtask

task automatic test_reset();
  repeat (4)
  begin
    @(negedge clk);
    check_valids_low();
  end
  @(posedge clk);
  rst <= 1'b0;
  repeat (3)
  begin
    @(negedge clk);
    check_valids_low();
  end
endtask

task automatic fetch_check(input logic [31:0] addr);
  logic [63:0] beat;
  int n0;
  beat = exp_mem[addr[10:3]];
  n0 = ifu_done_cnt;
  @(posedge clk);
  ifu_araddr_i  <= addr;
  ifu_arvalid_i <= 1'b1;
  do @(negedge clk); while (!ifu_rvalid_o);
  check_val("ifu_rdata_o", 64'(ifu_rdata_o), 64'(addr[2] ? beat[63:32] : beat[31:0]));
  @(posedge clk);
  ifu_arvalid_i <= 1'b0;
  settle();
  check_val("ifu_rvalid_o pulses", 64'(ifu_done_cnt - n0), 64'd1);
endtask

task automatic model_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
  int b;
  for (int i = 0; i < 4; i++)
  begin
    b = i + int'(addr[1:0]);
    if (strb[i] && b < 4)
      exp_mem[addr[10:3]][32*int'(addr[2]) + 8*b +: 8] = data[8*i +: 8];
  end
endtask

task automatic store_check(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
  int n0;
  logic [2:0] sz;
  n0 = wr_done_cnt;
  sz = (strb == 4'h1) ? 3'd0 : (strb == 4'h3) ? 3'd1 : 3'd2;
  model_store(addr, data, strb);
  @(posedge clk);
  lsu_awaddr_i  <= addr;
  lsu_wdata_i   <= data;
  lsu_wstrb_i   <= {4'h0, strb};
  lsu_awvalid_i <= 1'b1;
  lsu_wvalid_i  <= 1'b1;
  @(negedge clk);
  check_val("io_master_awsize_o", 64'(awsize), 64'(sz));
  while (!lsu_wready_o) @(negedge clk);
  @(posedge clk);
  lsu_awvalid_i <= 1'b0;
  lsu_wvalid_i  <= 1'b0;
  settle();
  check_val("lsu_wready_o pulses", 64'(wr_done_cnt - n0), 64'd1);
endtask

task automatic load_check(input logic [31:0] addr);
  logic [63:0] beat;
  int n0;
  beat = exp_mem[addr[10:3]];
  n0 = rd_done_cnt;
  @(posedge clk);
  lsu_araddr_i  <= addr;
  lsu_rstrb_i   <= 8'h0f;
  lsu_arvalid_i <= 1'b1;
  do @(negedge clk); while (!lsu_rvalid_o);
  check_val("lsu_rdata_o", 64'(lsu_rdata_o), 64'(addr[2] ? beat[63:32] : beat[31:0]));
  @(posedge clk);
  lsu_arvalid_i <= 1'b0;
  settle();
  check_val("lsu_rvalid_o pulses", 64'(rd_done_cnt - n0), 64'd1);
endtask

task automatic test_fetch();
  fetch_check(32'h0000_0000);
  fetch_check(32'h0000_0004);
  fetch_check(32'h0000_0038);
  fetch_check(32'h0000_007c);
  fetch_check(32'h0000_0104);
endtask

task automatic test_store_load(input logic [31:0] base);
  logic [3:0]  strbs [3];
  logic [31:0] addr;
  int k;
  strbs = '{4'h1, 4'h3, 4'hf};
  k = 0;
  foreach (strbs[s])
    for (int off = 0; off < 4; off++)
    begin
      addr = 32'h0000_0200 + 32'(k * 4) + 32'(off);
      store_check(addr, base + 32'(k) * 32'h0101_0101, strbs[s]);
      load_check(addr & ~32'h3);
      k++;
    end
endtask

task automatic test_priority();
  logic [63:0] beat;
  beat = exp_mem[8'h21];
  @(posedge clk);
  ifu_araddr_i  <= 32'h0000_010c;
  ifu_arvalid_i <= 1'b1;
  lsu_araddr_i  <= 32'h0000_0108;
  lsu_rstrb_i   <= 8'h0f;
  lsu_arvalid_i <= 1'b1;
  do @(negedge clk); while (!lsu_rvalid_o && !ifu_rvalid_o);
  check_val("ifu_rvalid_o before lsu", 64'(ifu_rvalid_o), 64'd0);
  check_val("lsu_rdata_o", 64'(lsu_rdata_o), 64'(beat[31:0]));
  @(posedge clk);
  lsu_arvalid_i <= 1'b0;
  do @(negedge clk); while (!ifu_rvalid_o);
  check_val("ifu_rdata_o", 64'(ifu_rdata_o), 64'(beat[63:32]));
  @(posedge clk);
  ifu_arvalid_i <= 1'b0;
  settle();
endtask

task automatic timer_read(input logic [31:0] addr, output logic [31:0] val, output int t);
  int lat;
  @(posedge clk);
  lsu_araddr_i  <= addr;
  lsu_rstrb_i   <= 8'h0f;
  lsu_arvalid_i <= 1'b1;
  lat = 0;
  do
  begin
    @(negedge clk);
    lat++;
  end
  while (!lsu_rvalid_o);
  val = lsu_rdata_o;
  t = cyc;
  // request cycle, LS_ADDR accept cycle, then the done cycle
  check_val("lsu_rvalid_o latency", 64'(lat), 64'd3);
  @(posedge clk);
  lsu_arvalid_i <= 1'b0;
endtask

task automatic test_timer();
  logic [31:0] v1, v2, hi;
  int t1, t2, t3, a0;
  a0 = ar_cnt;
  timer_read(bus_pkg::RTC_ADDR_LO, v1, t1);
  repeat (7) @(posedge clk);
  timer_read(bus_pkg::RTC_ADDR_LO, v2, t2);
  assert (v2 > v1)
  else
    fail_run("timer low word did not rise between two reads");
  assert ((v2 - v1) >= 32'(t2 - t1))
  else
    fail_run("timer advanced less than the number of elapsed cycles");
  timer_read(bus_pkg::RTC_ADDR_HI, hi, t3);
  check_val("mtime high word", 64'(hi), 64'h0);
  settle();
  check_val("io_master_arvalid_o count", 64'(ar_cnt - a0), 64'd0);
endtask

task automatic run_tests();
  test_reset();
  test_fetch();
  test_store_load(32'h1122_3344);
  test_priority();
  test_timer();
  rand_delay = 1'b1; // back-pressure pass
  test_fetch();
  test_store_load(32'h9a8b_7c6d);
endtask

`endif

/* testbench/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

  localparam int NUM_TESTS = 6;

  logic        clk;
  logic        rst;
  logic [31:0] ifu_araddr_i;
  logic        ifu_arvalid_i;
  logic [31:0] ifu_rdata_o;
  logic        ifu_rvalid_o;
  logic [31:0] lsu_araddr_i;
  logic        lsu_arvalid_i;
  logic [7:0]  lsu_rstrb_i;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_awaddr_i;
  logic        lsu_awvalid_i;
  logic [31:0] lsu_wdata_i;
  logic [7:0]  lsu_wstrb_i;
  logic        lsu_wvalid_i;
  logic        lsu_wready_o;

  logic [1:0]  arburst, awburst;
  logic [2:0]  arsize, awsize;
  logic [7:0]  arlen, awlen;
  logic [3:0]  arid, awid;
  logic [31:0] araddr, awaddr;
  logic        arvalid, arready, awvalid, awready;
  logic [63:0] rdata, wdata;
  logic        rvalid, rready, wvalid, wready, wlast, bvalid, bready;
  logic [7:0]  wstrb;

  logic [63:0] mem [0:255];     // responder memory
  logic [63:0] exp_mem [0:255]; // expected contents
  logic [31:0] lfsr_state;
  bit          rand_delay;
  int          ifu_done_cnt, rd_done_cnt, wr_done_cnt, ar_cnt;
  int          cyc;

  core_bus_top #(
    .ADDR_W(32),
    .DATA_W(32)
  ) core_bus_top_inst (
    .clk(clk), .rst(rst),
    .ifu_araddr_i(ifu_araddr_i), .ifu_arvalid_i(ifu_arvalid_i),
    .ifu_rdata_o(ifu_rdata_o), .ifu_rvalid_o(ifu_rvalid_o),
    .lsu_araddr_i(lsu_araddr_i), .lsu_arvalid_i(lsu_arvalid_i), .lsu_rstrb_i(lsu_rstrb_i),
    .lsu_rdata_o(lsu_rdata_o), .lsu_rvalid_o(lsu_rvalid_o),
    .lsu_awaddr_i(lsu_awaddr_i), .lsu_awvalid_i(lsu_awvalid_i), .lsu_wdata_i(lsu_wdata_i),
    .lsu_wstrb_i(lsu_wstrb_i), .lsu_wvalid_i(lsu_wvalid_i), .lsu_wready_o(lsu_wready_o),
    .io_master_arburst_o(arburst), .io_master_arsize_o(arsize), .io_master_arlen_o(arlen),
    .io_master_arid_o(arid), .io_master_araddr_o(araddr), .io_master_arvalid_o(arvalid),
    .io_master_arready_i(arready), .io_master_rdata_i(rdata), .io_master_rresp_i(2'b00),
    .io_master_rvalid_i(rvalid), .io_master_rready_o(rready),
    .io_master_awburst_o(awburst), .io_master_awsize_o(awsize), .io_master_awlen_o(awlen),
    .io_master_awid_o(awid), .io_master_awaddr_o(awaddr), .io_master_awvalid_o(awvalid),
    .io_master_awready_i(awready), .io_master_wlast_o(wlast), .io_master_wdata_o(wdata),
    .io_master_wstrb_o(wstrb), .io_master_wvalid_o(wvalid), .io_master_wready_i(wready),
    .io_master_bresp_i(2'b00), .io_master_bvalid_i(bvalid), .io_master_bready_o(bready)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois form, taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_delay(output int d);
    d = 0;
    if (rand_delay)
    begin
      repeat (2)
      begin
        d = (d << 1) | int'(lfsr_state[0]);
        lfsr_state = lfsr_next(lfsr_state);
      end
    end
  endtask

  function automatic logic [63:0] fill_beat(input int idx);
    logic [31:0] a;
    a = 32'(idx) << 3;
    fill_beat = {a ^ 32'ha5a5_0004, a ^ 32'h5a5a_0000};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
      fail_run($sformatf("ERR %s got=%h exp=%h", name, got, exp));
  endtask

  always @(posedge clk)
    cyc <= cyc + 1;

  // done pulse and ar counters
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (ifu_rvalid_o) ifu_done_cnt++;
      if (lsu_rvalid_o) rd_done_cnt++;
      if (lsu_wready_o) wr_done_cnt++;
      if (arvalid) ar_cnt++;
    end
  end

  // tied axi fields while their channel is active
  always @(negedge clk)
  begin
    if (!rst)
    begin
      check_val("io_master_rready_o", 64'(rready), 64'd1);
      check_val("io_master_bready_o", 64'(bready), 64'd1);
      if (arvalid)
      begin
        check_val("io_master_arsize_o", 64'(arsize), 64'd2);
        check_val("io_master_arlen_o", 64'(arlen), 64'd0);
        check_val("io_master_arburst_o", 64'(arburst), 64'd1);
        check_val("io_master_arid_o", 64'(arid), 64'd0);
      end
      if (awvalid)
      begin
        check_val("io_master_awlen_o", 64'(awlen), 64'd0);
        check_val("io_master_awburst_o", 64'(awburst), 64'd1);
        check_val("io_master_awid_o", 64'(awid), 64'd0);
      end
      if (wvalid)
        check_val("io_master_wlast_o", 64'(wlast), 64'd1);
    end
  end

  initial
  begin : read_responder
    int d;
    logic [31:0] a;
    forever
    begin
      @(negedge clk);
      if (!rst && arvalid)
      begin
        a = araddr;
        draw_delay(d);
        repeat (d) @(posedge clk);
        @(posedge clk);
        arready <= 1'b1;
        @(negedge clk);
        check_val("io_master_arvalid_o", 64'(arvalid), 64'd1);
        check_val("io_master_araddr_o", 64'(araddr), 64'(a));
        @(posedge clk);
        arready <= 1'b0;
        draw_delay(d);
        repeat (d) @(posedge clk);
        rdata  <= mem[a[10:3]];
        rvalid <= 1'b1;
        @(negedge clk);
        check_val("ifu_rvalid_o|lsu_rvalid_o", 64'(ifu_rvalid_o | lsu_rvalid_o), 64'd1);
        @(posedge clk);
        rvalid <= 1'b0;
      end
    end
  end

  initial
  begin : write_responder
    int da, dw, db;
    logic [31:0] wa;
    logic [63:0] wd;
    logic [7:0]  ws;
    forever
    begin
      @(negedge clk);
      if (!rst && awvalid)
      begin
        draw_delay(da);
        draw_delay(dw);
        fork
          begin
            repeat (da) @(posedge clk);
            @(posedge clk);
            awready <= 1'b1;
            @(negedge clk);
            check_val("io_master_awvalid_o", 64'(awvalid), 64'd1);
            wa = awaddr;
            @(posedge clk);
            awready <= 1'b0;
          end
          begin
            repeat (dw) @(posedge clk);
            @(posedge clk);
            wready <= 1'b1;
            @(negedge clk);
            check_val("io_master_wvalid_o", 64'(wvalid), 64'd1);
            wd = wdata;
            ws = wstrb;
            @(posedge clk);
            wready <= 1'b0;
          end
        join
        draw_delay(db);
        repeat (db) @(posedge clk);
        for (int i = 0; i < 8; i++)
          if (ws[i]) mem[wa[10:3]][8*i +: 8] = wd[8*i +: 8];
        bvalid <= 1'b1;
        @(negedge clk);
        check_val("lsu_wready_o", 64'(lsu_wready_o), 64'd1);
        @(posedge clk);
        bvalid <= 1'b0;
      end
    end
  end

  `include "tb_tests.svh"

  initial
  begin
    rst = 1'b1;
    ifu_araddr_i = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i = '0;
    lsu_arvalid_i = 1'b0;
    lsu_rstrb_i = '0;
    lsu_awaddr_i = '0;
    lsu_awvalid_i = 1'b0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    lsu_wvalid_i = 1'b0;
    arready = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    rvalid = 1'b0;
    bvalid = 1'b0;
    rdata = '0;
    lfsr_state = 32'hd3d7b45f;
    rand_delay = 1'b0;
    cyc = 0;
    for (int i = 0; i < 256; i++)
    begin
      mem[i] = fill_beat(i);
      exp_mem[i] = fill_beat(i);
    end
    run_tests();
    $display("All tests passed");
    $finish;
  end

  initial
  begin : watchdog
    repeat (NUM_TESTS * 2000) @(posedge clk);
    fail_run("timeout, the tests did not finish in the allowed number of cycles");
  end

endmodule

/* tb.f */
+incdir+testbench
src/bus_pkg.sv
src/mem_arbiter.sv
src/axi_lane_align.sv
src/clint_timer.sv
src/core_bus_top.sv
testbench/tb_top.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wno-fatal --top-module tb_top -f tb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o Vtb_top
	./obj_dir/Vtb_top 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
